// File: verilog/accel_pkg.sv
package accel_pkg;

	// lane layout of the datapath
	localparam int LANES         = 4;
	localparam int FEATURE_WIDTH = 8;
	localparam int WEIGHT_WIDTH  = 8;
	localparam int ACC_WIDTH     = 24;

	localparam int PATCH_CNT_WIDTH = 8;

	// order codes seen on the task interface
	localparam int ORDER_WIDTH = 3;
	localparam logic [ORDER_WIDTH-1:0] ORDER_CONVOLUTION = 3'd1;

	localparam int SHIFT_WIDTH = 4;
	localparam int RESULT_MAX  = 127; // upper clamp of the output byte

	typedef logic signed [FEATURE_WIDTH-1:0] feature_t;
	typedef logic signed [WEIGHT_WIDTH-1:0]  weight_t;
	typedef logic signed [ACC_WIDTH-1:0]     acc_t;
	typedef logic [7:0]                      result_t;

endpackage

// File: verilog/wb_pkg.sv
package wb_pkg;

	localparam int WB_ADDR_WIDTH = 32;
	localparam int WB_DATA_WIDTH = accel_pkg::LANES * 8; // one byte per lane

	typedef logic [WB_ADDR_WIDTH-1:0] wb_addr_t; // word address
	typedef logic [WB_DATA_WIDTH-1:0] wb_data_t;

endpackage

// File: verilog/conv_control.sv
`timescale 1ns/1ps

module conv_control (
	input  logic                                  system_clk,
	input  logic                                  rst_n,
	input  logic                                  task_start,
	input  logic                                  task_finish,
	input  logic                                  calculate_start,
	input  logic [accel_pkg::ORDER_WIDTH-1:0]     order,
	input  wb_pkg::wb_addr_t                      feature_input_base_addr,
	input  wb_pkg::wb_addr_t                      weight_base_addr,
	input  wb_pkg::wb_addr_t                      return_addr,
	input  logic [accel_pkg::PATCH_CNT_WIDTH-1:0] feature_input_patch_num,
	input  logic [accel_pkg::PATCH_CNT_WIDTH-1:0] feature_output_patch_num,
	input  logic                                  bus_done,
	input  logic                                  psum_valid,
	input  logic                                  result_valid,
	output logic                                  calculate_finish,
	output logic                                  bus_req,
	output logic                                  bus_we,
	output wb_pkg::wb_addr_t                      bus_addr,
	output logic                                  load_weight,
	output logic                                  load_feature,
	output logic                                  mac_start,
	output logic                                  first_patch,
	output logic                                  last_patch
);
	import accel_pkg::*;
	import wb_pkg::*;

	typedef enum logic [1:0] {
		TASK_WAIT_TASK,
		TASK_WAIT_ORDER,
		TASK_WAIT_CONV
	} task_state_t;

	typedef enum logic [3:0] {
		CONV_IDLE,
		CONV_FETCH_WEIGHT,
		CONV_FETCH_FEATURE,
		CONV_START_MAC,
		CONV_WAIT_PSUM,
		CONV_CHECK_INPUT,
		CONV_WAIT_RESULT,
		CONV_WRITE_BACK,
		CONV_CHECK_OUTPUT,
		CONV_FINISH
	} conv_state_t;

	task_state_t task_state;
	conv_state_t conv_state;
	logic [PATCH_CNT_WIDTH-1:0]   input_patch_cnt;
	logic [PATCH_CNT_WIDTH-1:0]   output_patch_cnt;
	logic [2*PATCH_CNT_WIDTH-1:0] weight_idx;
	logic                         bus_pending; // request issued, waiting for done
	logic                         bus_state;

	always_ff @(posedge system_clk or negedge rst_n) begin
		if (!rst_n) begin
			task_state <= TASK_WAIT_TASK;
		end else begin
			case (task_state)
				TASK_WAIT_TASK: begin
					if (task_start) begin
						task_state <= TASK_WAIT_ORDER;
					end
				end
				TASK_WAIT_ORDER: begin
					if (calculate_start && order == ORDER_CONVOLUTION) begin
						task_state <= TASK_WAIT_CONV;
					end else if (task_finish) begin
						task_state <= TASK_WAIT_TASK;
					end
				end
				TASK_WAIT_CONV: begin
					if (conv_state == CONV_FINISH) begin
						task_state <= TASK_WAIT_ORDER;
					end
				end
				default: task_state <= TASK_WAIT_TASK;
			endcase
		end
	end

	always_ff @(posedge system_clk or negedge rst_n) begin
		if (!rst_n) begin
			conv_state <= CONV_IDLE;
		end else begin
			case (conv_state)
				CONV_IDLE: begin
					if (task_state == TASK_WAIT_CONV) begin
						conv_state <= CONV_FETCH_WEIGHT;
					end
				end
				CONV_FETCH_WEIGHT: begin
					if (bus_done) begin
						conv_state <= CONV_FETCH_FEATURE;
					end
				end
				CONV_FETCH_FEATURE: begin
					if (bus_done) begin
						conv_state <= CONV_START_MAC;
					end
				end
				CONV_START_MAC: conv_state <= CONV_WAIT_PSUM;
				CONV_WAIT_PSUM: begin
					if (psum_valid) begin
						conv_state <= CONV_CHECK_INPUT;
					end
				end
				CONV_CHECK_INPUT: begin
					if (input_patch_cnt == feature_input_patch_num) begin
						conv_state <= CONV_WAIT_RESULT;
					end else begin
						conv_state <= CONV_FETCH_WEIGHT;
					end
				end
				CONV_WAIT_RESULT: begin
					if (result_valid) begin
						conv_state <= CONV_WRITE_BACK;
					end
				end
				CONV_WRITE_BACK: begin
					if (bus_done) begin
						conv_state <= CONV_CHECK_OUTPUT;
					end
				end
				CONV_CHECK_OUTPUT: begin
					if (output_patch_cnt == feature_output_patch_num) begin
						conv_state <= CONV_FINISH;
					end else begin
						conv_state <= CONV_FETCH_WEIGHT;
					end
				end
				default: conv_state <= CONV_IDLE; // finish and recovery
			endcase
		end
	end

	always_ff @(posedge system_clk or negedge rst_n) begin
		if (!rst_n) begin
			input_patch_cnt <= '0;
		end else if (conv_state == CONV_IDLE) begin
			input_patch_cnt <= '0;
		end else if (conv_state == CONV_WAIT_PSUM && psum_valid) begin
			input_patch_cnt <= input_patch_cnt + 1'b1;
		end else if (conv_state == CONV_CHECK_INPUT &&
			input_patch_cnt == feature_input_patch_num) begin
			input_patch_cnt <= '0;
		end
	end

	always_ff @(posedge system_clk or negedge rst_n) begin
		if (!rst_n) begin
			output_patch_cnt <= '0;
		end else if (conv_state == CONV_WRITE_BACK && bus_done) begin
			output_patch_cnt <= output_patch_cnt + 1'b1;
		end else if (conv_state == CONV_FINISH) begin
			output_patch_cnt <= '0;
		end
	end

	// weights are stored output-major, so one running index covers o*n+i
	always_ff @(posedge system_clk or negedge rst_n) begin
		if (!rst_n) begin
			weight_idx <= '0;
		end else if (conv_state == CONV_IDLE) begin
			weight_idx <= '0;
		end else if (conv_state == CONV_FETCH_WEIGHT && bus_done) begin
			weight_idx <= weight_idx + 1'b1;
		end
	end

	always_ff @(posedge system_clk or negedge rst_n) begin
		if (!rst_n) begin
			bus_pending <= 1'b0;
		end else if (bus_done) begin
			bus_pending <= 1'b0;
		end else if (bus_req) begin
			bus_pending <= 1'b1;
		end
	end

	assign bus_state = (conv_state == CONV_FETCH_WEIGHT) ||
		(conv_state == CONV_FETCH_FEATURE) || (conv_state == CONV_WRITE_BACK);
	assign bus_req = bus_state && !bus_pending; // single cycle pulse
	assign bus_we  = (conv_state == CONV_WRITE_BACK);

	always_comb begin
		case (conv_state)
			CONV_FETCH_WEIGHT:  bus_addr = weight_base_addr + wb_addr_t'(weight_idx);
			CONV_FETCH_FEATURE: bus_addr = feature_input_base_addr + wb_addr_t'(input_patch_cnt);
			default:            bus_addr = return_addr + wb_addr_t'(output_patch_cnt);
		endcase
	end

	assign load_weight  = (conv_state == CONV_FETCH_WEIGHT) && bus_done;
	assign load_feature = (conv_state == CONV_FETCH_FEATURE) && bus_done;
	assign mac_start    = (conv_state == CONV_START_MAC);
	assign first_patch  = (input_patch_cnt == '0);
	assign last_patch   = (input_patch_cnt == feature_input_patch_num - 1'b1);

	assign calculate_finish = (task_state != TASK_WAIT_CONV);

	// zero counts would never reach the compare in the check states
	assert property (@(posedge system_clk) disable iff (!rst_n)
		(conv_state == CONV_IDLE && task_state == TASK_WAIT_CONV) |->
		(feature_input_patch_num != '0 && feature_output_patch_num != '0))
		else $error("convolution started with a zero patch count");

endmodule

// File: verilog/wb_master.sv
`timescale 1ns/1ps

module wb_master (
	input  logic             system_clk,
	input  logic             rst_n,
	input  logic             bus_req,
	input  logic             bus_we,
	input  wb_pkg::wb_addr_t bus_addr,
	input  wb_pkg::wb_data_t bus_wdata,
	output logic             bus_done,
	output wb_pkg::wb_data_t bus_rdata,
	output logic             wb_cyc,
	output logic             wb_stb,
	output logic             wb_we,
	output wb_pkg::wb_addr_t wb_adr,
	output wb_pkg::wb_data_t wb_wdata,
	input  wb_pkg::wb_data_t wb_rdata,
	input  logic             wb_ack
);
	import wb_pkg::*;

	typedef enum logic {
		MST_IDLE,
		MST_ACTIVE
	} mst_state_t;

	mst_state_t state;
	wb_addr_t   adr_q;
	wb_data_t   wdata_q;
	wb_data_t   rdata_q;
	logic       we_q;
	logic       done_q;

	always_ff @(posedge system_clk or negedge rst_n) begin
		if (!rst_n) begin
			state  <= MST_IDLE;
			we_q   <= 1'b0;
			done_q <= 1'b0;
		end else begin
			done_q <= 1'b0;
			if (state == MST_IDLE && bus_req) begin
				state <= MST_ACTIVE;
				we_q  <= bus_we;
			end else if (state == MST_ACTIVE && wb_ack) begin
				state  <= MST_IDLE; // cyc drops the cycle after ack
				done_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge system_clk) begin
		if (state == MST_IDLE && bus_req) begin
			adr_q   <= bus_addr;
			wdata_q <= bus_wdata;
		end
		if (state == MST_ACTIVE && wb_ack && !we_q) begin
			rdata_q <= wb_rdata;
		end
	end

	assign wb_cyc    = (state == MST_ACTIVE);
	assign wb_stb    = (state == MST_ACTIVE);
	assign wb_we     = we_q;
	assign wb_adr    = adr_q;
	assign wb_wdata  = wdata_q;
	assign bus_done  = done_q;
	assign bus_rdata = rdata_q;

	assert property (@(posedge system_clk) disable iff (!rst_n) wb_stb |-> wb_cyc)
		else $error("strobe raised outside a bus cycle");

	// controller must wait for done before the next request
	assert property (@(posedge system_clk) disable iff (!rst_n)
		bus_req |-> (state == MST_IDLE))
		else $error("bus request while a transfer is in flight");

endmodule

// File: verilog/mac_core.sv
`timescale 1ns/1ps

module mac_core (
	input  logic             system_clk,
	input  logic             rst_n,
	input  logic             load_weight,
	input  logic             load_feature,
	input  logic             mac_start,
	input  wb_pkg::wb_data_t operand,
	output logic             psum_valid,
	output accel_pkg::acc_t  psum
);
	import accel_pkg::*;
	import wb_pkg::*;

	wb_data_t weight_word;
	wb_data_t feature_word;
	weight_t  weight_lane  [LANES];
	feature_t feature_lane [LANES];
	logic signed [WEIGHT_WIDTH+FEATURE_WIDTH-1:0] prod_q [LANES];
	logic     stage1_valid;
	acc_t     sum_next;

	always_ff @(posedge system_clk) begin
		if (load_weight) begin
			weight_word <= operand;
		end
		if (load_feature) begin
			feature_word <= operand;
		end
	end

	always_comb begin
		for (int l = 0; l < LANES; l++) begin
			weight_lane[l]  = weight_t'(weight_word[l*WEIGHT_WIDTH +: WEIGHT_WIDTH]);
			feature_lane[l] = feature_t'(feature_word[l*FEATURE_WIDTH +: FEATURE_WIDTH]);
		end
	end

	// stage one, lane products
	always_ff @(posedge system_clk) begin
		if (mac_start) begin
			for (int l = 0; l < LANES; l++) begin
				prod_q[l] <= weight_lane[l] * feature_lane[l];
			end
		end
	end

	always_comb begin
		sum_next = '0;
		for (int l = 0; l < LANES; l++) begin
			sum_next = sum_next + acc_t'(prod_q[l]); // sign extended
		end
	end

	// stage two, add tree
	always_ff @(posedge system_clk) begin
		if (stage1_valid) begin
			psum <= sum_next;
		end
	end

	always_ff @(posedge system_clk or negedge rst_n) begin
		if (!rst_n) begin
			stage1_valid <= 1'b0;
			psum_valid   <= 1'b0;
		end else begin
			stage1_valid <= mac_start;
			psum_valid   <= stage1_valid;
		end
	end

	assert property (@(posedge system_clk) disable iff (!rst_n)
		mac_start |-> !(stage1_valid || psum_valid))
		else $error("mac_start while the MAC pipeline is busy");

endmodule

// File: verilog/psum_accumulator.sv
`timescale 1ns/1ps

module psum_accumulator (
	input  logic            system_clk,
	input  logic            rst_n,
	input  logic            psum_valid,
	input  logic            first_patch,
	input  logic            last_patch,
	input  accel_pkg::acc_t psum,
	output logic            acc_valid,
	output accel_pkg::acc_t acc_sum
);
	import accel_pkg::*;

	acc_t sum_q;

	always_ff @(posedge system_clk) begin
		if (psum_valid) begin
			if (first_patch) begin
				sum_q <= psum; // new output patch
			end else begin
				sum_q <= sum_q + psum;
			end
		end
	end

	always_ff @(posedge system_clk or negedge rst_n) begin
		if (!rst_n) begin
			acc_valid <= 1'b0;
		end else begin
			acc_valid <= psum_valid && last_patch;
		end
	end

	assign acc_sum = sum_q;

endmodule

// File: verilog/activation_quant.sv
`timescale 1ns/1ps

module activation_quant (
	input  logic                              system_clk,
	input  logic                              rst_n,
	input  logic                              acc_valid,
	input  accel_pkg::acc_t                   acc_sum,
	input  logic [accel_pkg::SHIFT_WIDTH-1:0] out_shift,
	output logic                              result_valid,
	output accel_pkg::result_t                result
);
	import accel_pkg::*;

	acc_t    shifted;
	result_t result_next;

	always_comb begin
		shifted = acc_sum >>> out_shift;
		if (acc_sum < 0) begin
			result_next = '0; // relu
		end else if (shifted > acc_t'(RESULT_MAX)) begin
			result_next = result_t'(RESULT_MAX);
		end else begin
			result_next = result_t'(shifted);
		end
	end

	// held until the next total arrives
	always_ff @(posedge system_clk) begin
		if (acc_valid) begin
			result <= result_next;
		end
	end

	always_ff @(posedge system_clk or negedge rst_n) begin
		if (!rst_n) begin
			result_valid <= 1'b0;
		end else begin
			result_valid <= acc_valid;
		end
	end

endmodule

// File: verilog/accel_top.sv
`timescale 1ns/1ps

module accel_top (
	input  logic                                  system_clk,
	input  logic                                  rst_n,
	input  logic                                  task_start,
	input  logic                                  task_finish,
	input  logic                                  calculate_start,
	output logic                                  calculate_finish,
	input  logic [accel_pkg::ORDER_WIDTH-1:0]     order,
	input  wb_pkg::wb_addr_t                      feature_input_base_addr,
	input  wb_pkg::wb_addr_t                      weight_base_addr,
	input  wb_pkg::wb_addr_t                      return_addr,
	input  logic [accel_pkg::PATCH_CNT_WIDTH-1:0] feature_input_patch_num,
	input  logic [accel_pkg::PATCH_CNT_WIDTH-1:0] feature_output_patch_num,
	input  logic [accel_pkg::SHIFT_WIDTH-1:0]     out_shift,
	output logic                                  wb_cyc,
	output logic                                  wb_stb,
	output logic                                  wb_we,
	output wb_pkg::wb_addr_t                      wb_adr,
	output wb_pkg::wb_data_t                      wb_wdata,
	input  wb_pkg::wb_data_t                      wb_rdata,
	input  logic                                  wb_ack
);
	import accel_pkg::*;
	import wb_pkg::*;

	logic     bus_req;
	logic     bus_we;
	logic     bus_done;
	wb_addr_t bus_addr;
	wb_data_t bus_wdata;
	wb_data_t bus_rdata;
	logic     load_weight;
	logic     load_feature;
	logic     mac_start;
	logic     first_patch;
	logic     last_patch;
	logic     psum_valid;
	acc_t     psum;
	logic     acc_valid;
	acc_t     acc_sum;
	logic     result_valid;
	result_t  result;

	assign bus_wdata = wb_data_t'(result); // zero extended byte

	conv_control u_conv_control (
		.system_clk               ( system_clk               ),
		.rst_n                    ( rst_n                    ),
		.task_start               ( task_start               ),
		.task_finish              ( task_finish              ),
		.calculate_start          ( calculate_start          ),
		.order                    ( order                    ),
		.feature_input_base_addr  ( feature_input_base_addr  ),
		.weight_base_addr         ( weight_base_addr         ),
		.return_addr              ( return_addr              ),
		.feature_input_patch_num  ( feature_input_patch_num  ),
		.feature_output_patch_num ( feature_output_patch_num ),
		.bus_done                 ( bus_done                 ),
		.psum_valid               ( psum_valid               ),
		.result_valid             ( result_valid             ),
		.calculate_finish         ( calculate_finish         ),
		.bus_req                  ( bus_req                  ),
		.bus_we                   ( bus_we                   ),
		.bus_addr                 ( bus_addr                 ),
		.load_weight              ( load_weight              ),
		.load_feature             ( load_feature             ),
		.mac_start                ( mac_start                ),
		.first_patch              ( first_patch              ),
		.last_patch               ( last_patch               )
	);

	wb_master u_wb_master (
		.system_clk ( system_clk ),
		.rst_n      ( rst_n      ),
		.bus_req    ( bus_req    ),
		.bus_we     ( bus_we     ),
		.bus_addr   ( bus_addr   ),
		.bus_wdata  ( bus_wdata  ),
		.bus_done   ( bus_done   ),
		.bus_rdata  ( bus_rdata  ),
		.wb_cyc     ( wb_cyc     ),
		.wb_stb     ( wb_stb     ),
		.wb_we      ( wb_we      ),
		.wb_adr     ( wb_adr     ),
		.wb_wdata   ( wb_wdata   ),
		.wb_rdata   ( wb_rdata   ),
		.wb_ack     ( wb_ack     )
	);

	mac_core u_mac_core (
		.system_clk   ( system_clk   ),
		.rst_n        ( rst_n        ),
		.load_weight  ( load_weight  ),
		.load_feature ( load_feature ),
		.mac_start    ( mac_start    ),
		.operand      ( bus_rdata    ),
		.psum_valid   ( psum_valid   ),
		.psum         ( psum         )
	);

	psum_accumulator u_psum_accumulator (
		.system_clk  ( system_clk  ),
		.rst_n       ( rst_n       ),
		.psum_valid  ( psum_valid  ),
		.first_patch ( first_patch ),
		.last_patch  ( last_patch  ),
		.psum        ( psum        ),
		.acc_valid   ( acc_valid   ),
		.acc_sum     ( acc_sum     )
	);

	activation_quant u_activation_quant (
		.system_clk   ( system_clk   ),
		.rst_n        ( rst_n        ),
		.acc_valid    ( acc_valid    ),
		.acc_sum      ( acc_sum      ),
		.out_shift    ( out_shift    ),
		.result_valid ( result_valid ),
		.result       ( result       )
	);

endmodule

// File: verification/wb_mem_model.sv
`timescale 1ns/1ps

module wb_mem_model (
	input  logic                                  system_clk,
	input  logic                                  rst_n,
	input  logic                                  wb_cyc,
	input  logic                                  wb_stb,
	input  logic                                  wb_we,
	input  wb_pkg::wb_addr_t                      wb_adr,
	input  wb_pkg::wb_data_t                      wb_wdata,
	output wb_pkg::wb_data_t                      wb_rdata,
	output logic                                  wb_ack,
	input  logic [1:0]                            ack_delay,
	input  logic                                  fill_en,
	input  logic [7:0]                            fill_addr,
	input  wb_pkg::wb_data_t                      fill_data,
	input  wb_pkg::wb_addr_t                      weight_base_addr,
	input  wb_pkg::wb_addr_t                      feature_input_base_addr,
	input  wb_pkg::wb_addr_t                      return_addr,
	input  logic [accel_pkg::PATCH_CNT_WIDTH-1:0] feature_input_patch_num,
	input  logic [accel_pkg::PATCH_CNT_WIDTH-1:0] feature_output_patch_num,
	input  logic [accel_pkg::SHIFT_WIDTH-1:0]     out_shift,
	output int                                    error_count,
	output int                                    check_count
);
	import accel_pkg::*;
	import wb_pkg::*;

	wb_data_t   mem [256]; // word addressed by adr[7:0]
	logic       busy;
	logic [1:0] wait_cnt;
	wb_addr_t   write_idx;

	// 1x1 convolution result of output patch o, from the words held here
	function automatic wb_data_t expected_word(input int o);
		int       sum;
		int       w_lane;
		int       f_lane;
		wb_addr_t w_addr;
		wb_addr_t f_addr;
		sum = 0;
		for (int i = 0; i < int'(feature_input_patch_num); i++) begin
			w_addr = weight_base_addr + wb_addr_t'(o * int'(feature_input_patch_num) + i);
			f_addr = feature_input_base_addr + wb_addr_t'(i);
			for (int l = 0; l < LANES; l++) begin
				w_lane = int'($signed(mem[w_addr[7:0]][8*l +: 8]));
				f_lane = int'($signed(mem[f_addr[7:0]][8*l +: 8]));
				sum += w_lane * f_lane;
			end
		end
		if (sum < 0) begin
			sum = 0; // relu
		end
		sum = sum >>> out_shift;
		if (sum > RESULT_MAX) begin
			sum = RESULT_MAX;
		end
		return wb_data_t'(sum);
	endfunction

	always @(posedge system_clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_ack   <= 1'b0;
			busy     <= 1'b0;
			wait_cnt <= 2'd0;
		end else begin
			wb_ack <= 1'b0;
			if (fill_en) begin
				mem[fill_addr] <= fill_data;
			end
			if (wb_cyc && wb_stb && !wb_ack) begin
				if (!busy) begin
					busy     <= 1'b1;
					wait_cnt <= ack_delay; // extra wait states
				end else if (wait_cnt == 2'd0) begin
					busy     <= 1'b0;
					wb_ack   <= 1'b1;
					wb_rdata <= mem[wb_adr[7:0]];
					if (wb_we) begin
						mem[wb_adr[7:0]] <= wb_wdata;
					end
				end else begin
					wait_cnt <= wait_cnt - 2'd1;
				end
			end
		end
	end

	// every completed write is compared with the reference result
	always @(posedge system_clk or negedge rst_n) begin
		if (!rst_n) begin
			error_count <= 0;
			check_count <= 0;
		end else if (wb_cyc && wb_stb && wb_we && wb_ack) begin
			write_idx = wb_adr - return_addr;
			check_count <= check_count + 1;
			assert (write_idx < wb_addr_t'(feature_output_patch_num) &&
				wb_wdata == expected_word(int'(write_idx)))
			else begin
				error_count <= error_count + 1;
				$display("FAIL %0t: write 0x%08h to 0x%08h, expected 0x%08h for patch %0d of %0d",
					$time, wb_wdata, wb_adr, expected_word(int'(write_idx)),
					write_idx, feature_output_patch_num);
			end
		end
	end

endmodule

// File: verification/tb_accel.sv
`timescale 1ns/1ps

module tb_accel;
	import accel_pkg::*;
	import wb_pkg::*;

	localparam logic [31:0] SEED = 32'h47dc_a5fc;
	// fill plus three runs of at most 4x4 patches stay under 2000 cycles at the slowest ack
	localparam int TIMEOUT_CYCLES = 20000;

	logic                       system_clk;
	logic                       rst_n;
	logic                       task_start;
	logic                       task_finish;
	logic                       calculate_start;
	logic                       calculate_finish;
	logic [ORDER_WIDTH-1:0]     order;
	wb_addr_t                   feature_input_base_addr;
	wb_addr_t                   weight_base_addr;
	wb_addr_t                   return_addr;
	logic [PATCH_CNT_WIDTH-1:0] feature_input_patch_num;
	logic [PATCH_CNT_WIDTH-1:0] feature_output_patch_num;
	logic [SHIFT_WIDTH-1:0]     out_shift;
	logic                       wb_cyc;
	logic                       wb_stb;
	logic                       wb_we;
	wb_addr_t                   wb_adr;
	wb_data_t                   wb_wdata;
	wb_data_t                   wb_rdata;
	logic                       wb_ack;

	logic        fill_en;
	logic [7:0]  fill_addr;
	wb_data_t    fill_data;
	logic [1:0]  ack_delay = 2'd0;
	logic [31:0] fill_state = SEED;
	logic [31:0] delay_state = SEED;
	logic        task_open;
	logic        conv_accept;
	int          write_count = 0;
	int          expected_writes = 0;
	int          cycle_count = 0;
	int          protocol_errors = 0;
	int          control_errors = 0;
	int          run_errors = 0;
	int          write_errors;
	int          write_checks;

	accel_top i_dut (
		.system_clk               ( system_clk               ),
		.rst_n                    ( rst_n                    ),
		.task_start               ( task_start               ),
		.task_finish              ( task_finish              ),
		.calculate_start          ( calculate_start          ),
		.calculate_finish         ( calculate_finish         ),
		.order                    ( order                    ),
		.feature_input_base_addr  ( feature_input_base_addr  ),
		.weight_base_addr         ( weight_base_addr         ),
		.return_addr              ( return_addr              ),
		.feature_input_patch_num  ( feature_input_patch_num  ),
		.feature_output_patch_num ( feature_output_patch_num ),
		.out_shift                ( out_shift                ),
		.wb_cyc                   ( wb_cyc                   ),
		.wb_stb                   ( wb_stb                   ),
		.wb_we                    ( wb_we                    ),
		.wb_adr                   ( wb_adr                   ),
		.wb_wdata                 ( wb_wdata                 ),
		.wb_rdata                 ( wb_rdata                 ),
		.wb_ack                   ( wb_ack                   )
	);

	wb_mem_model i_mem (
		.system_clk               ( system_clk               ),
		.rst_n                    ( rst_n                    ),
		.wb_cyc                   ( wb_cyc                   ),
		.wb_stb                   ( wb_stb                   ),
		.wb_we                    ( wb_we                    ),
		.wb_adr                   ( wb_adr                   ),
		.wb_wdata                 ( wb_wdata                 ),
		.wb_rdata                 ( wb_rdata                 ),
		.wb_ack                   ( wb_ack                   ),
		.ack_delay                ( ack_delay                ),
		.fill_en                  ( fill_en                  ),
		.fill_addr                ( fill_addr                ),
		.fill_data                ( fill_data                ),
		.weight_base_addr         ( weight_base_addr         ),
		.feature_input_base_addr  ( feature_input_base_addr  ),
		.return_addr              ( return_addr              ),
		.feature_input_patch_num  ( feature_input_patch_num  ),
		.feature_output_patch_num ( feature_output_patch_num ),
		.out_shift                ( out_shift                ),
		.error_count              ( write_errors             ),
		.check_count              ( write_checks             )
	);

	initial begin
		system_clk = 1'b0;
		forever begin
			#50 system_clk = ~system_clk;
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic int total_errors();
		return protocol_errors + control_errors + run_errors + write_errors;
	endfunction

	always @(posedge system_clk) begin
		delay_state = lcg_next(delay_state);
		ack_delay <= delay_state[17:16];
	end

	assign conv_accept = calculate_start && calculate_finish && task_open &&
		order == ORDER_CONVOLUTION;

	always @(posedge system_clk) begin
		if (conv_accept) begin
			write_count <= 0;
		end else if (wb_cyc && wb_stb && wb_we && wb_ack) begin
			write_count <= write_count + 1;
		end
	end

	assert property (@(posedge system_clk) disable iff (!rst_n) wb_stb |-> wb_cyc)
		else begin
			protocol_errors++;
			$display("bus protocol error at %0t: wb_stb high without wb_cyc", $time);
		end

	assert property (@(posedge system_clk) disable iff (!rst_n)
		wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_we) && $stable(wb_wdata))
		else begin
			protocol_errors++;
			$display("bus protocol error at %0t: strobe dropped or changed before its ack", $time);
		end

	assert property (@(posedge system_clk) disable iff (!rst_n) wb_cyc |-> !calculate_finish)
		else begin
			protocol_errors++;
			$display("bus protocol error at %0t: bus cycle while no convolution runs", $time);
		end

	assert property (@(posedge system_clk) disable iff (!rst_n) conv_accept |=> !calculate_finish)
		else begin
			control_errors++;
			$display("FAIL %0t: calculate_finish stayed high after an accepted start", $time);
		end

	assert property (@(posedge system_clk) disable iff (!rst_n)
		calculate_start && calculate_finish && !conv_accept |=> calculate_finish)
		else begin
			control_errors++;
			$display("FAIL %0t: calculate_finish dropped on a start that must be ignored", $time);
		end

	assert property (@(posedge system_clk) disable iff (!rst_n)
		$rose(calculate_finish) |-> write_count == int'(feature_output_patch_num))
		else begin
			control_errors++;
			$display("FAIL %0t: convolution ended after %0d writes, expected %0d",
				$time, write_count, feature_output_patch_num);
		end

	task automatic print_summary();
		$display("errors: %0d protocol, %0d control, %0d write data, %0d run; %0d of %0d writes checked",
			protocol_errors, control_errors, write_errors, run_errors, write_checks, expected_writes);
	endtask

	task automatic fill_memory();
		for (int a = 0; a < 256; a++) begin
			@(posedge system_clk);
			fill_state = lcg_next(fill_state);
			fill_en   <= 1'b1;
			fill_addr <= 8'(a);
			fill_data <= fill_state;
		end
		@(posedge system_clk);
		fill_en <= 1'b0;
	endtask

	task automatic pulse_task(input logic open_task);
		@(posedge system_clk);
		task_start  <= open_task;
		task_finish <= !open_task;
		task_open   <= open_task;
		@(posedge system_clk);
		task_start  <= 1'b0;
		task_finish <= 1'b0;
	endtask

	task automatic pulse_calculate(input logic [ORDER_WIDTH-1:0] ord);
		@(posedge system_clk);
		calculate_start <= 1'b1;
		order           <= ord;
		@(posedge system_clk);
		calculate_start <= 1'b0;
	endtask

	task automatic run_convolution(input logic [PATCH_CNT_WIDTH-1:0] n_in,
		input logic [PATCH_CNT_WIDTH-1:0] n_out, input logic [SHIFT_WIDTH-1:0] shift,
		input wb_addr_t w_base, input wb_addr_t f_base, input wb_addr_t r_base);
		@(posedge system_clk);
		feature_input_patch_num  <= n_in;
		feature_output_patch_num <= n_out;
		out_shift                <= shift;
		weight_base_addr         <= w_base;
		feature_input_base_addr  <= f_base;
		return_addr              <= r_base;
		expected_writes += int'(n_out);
		pulse_calculate(ORDER_CONVOLUTION);
		@(negedge system_clk);
		while (!calculate_finish) begin
			@(negedge system_clk);
		end
	endtask

	always @(posedge system_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES) begin
			$display("timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
			print_summary();
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	initial begin
		rst_n                    = 1'b0;
		task_start               = 1'b0;
		task_finish              = 1'b0;
		calculate_start          = 1'b0;
		order                    = '0;
		feature_input_base_addr  = '0;
		weight_base_addr         = '0;
		return_addr              = '0;
		feature_input_patch_num  = 8'd1;
		feature_output_patch_num = 8'd1;
		out_shift                = '0;
		fill_en                  = 1'b0;
		fill_addr                = '0;
		fill_data                = '0;
		task_open                = 1'b0;
		repeat (4) @(posedge system_clk);
		rst_n <= 1'b1;
		@(negedge system_clk);
		assert (calculate_finish === 1'b1 && wb_cyc === 1'b0) else begin
			run_errors++;
			$display("FAIL %0t: after reset calculate_finish=%b wb_cyc=%b",
				$time, calculate_finish, wb_cyc);
		end

		fill_memory();
		pulse_calculate(ORDER_CONVOLUTION); // no task open yet
		repeat (8) @(posedge system_clk);

		pulse_task(1'b1);
		run_convolution(8'd4, 8'd4, 4'd0, 32'h00, 32'h40, 32'h80); // mostly clamped
		pulse_calculate(3'd2);
		repeat (8) @(posedge system_clk);
		run_convolution(8'd3, 8'd4, 4'd15, 32'h10, 32'h48, 32'h90); // mostly zero
		pulse_task(1'b0);
		pulse_calculate(ORDER_CONVOLUTION);
		repeat (8) @(posedge system_clk);

		pulse_task(1'b1);
		run_convolution(8'd1, 8'd3, 4'd6, 32'h20, 32'h50, 32'ha0);
		pulse_task(1'b0);
		repeat (5) @(posedge system_clk);

		assert (write_checks == expected_writes) else begin
			run_errors++;
			$display("FAIL %0t: %0d writes seen, expected %0d", $time, write_checks, expected_writes);
		end
		print_summary();
		if (total_errors() == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// File: compile.f
verilog/accel_pkg.sv
verilog/wb_pkg.sv
verilog/conv_control.sv
verilog/wb_master.sv
verilog/mac_core.sv
verilog/psum_accumulator.sv
verilog/activation_quant.sv
verilog/accel_top.sv
verification/wb_mem_model.sv
verification/tb_accel.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
	-f compile.f \
	--top-module tb_accel \
	-Mdir obj_dir -o sim_accel

./obj_dir/sim_accel 2>&1 | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi
echo "simulation passed"
